// ==== src/hdr_split_join_pkg.sv ====
/* Shared widths, depths and the payload entry format of the header split and join
   subsystem. Every block of the datapath imports this package. */

`default_nettype none

package hdr_split_join_pkg;

   // ----------------------------------------------------------------------
   // beat format
   // ----------------------------------------------------------------------

   localparam int DATA_BYTES = 8;
   localparam int DATA_W     = DATA_BYTES * 8;

   // every packet carries a small rolling tag on its header and its payload.
   localparam int TAG_W = 4;

   // ----------------------------------------------------------------------
   // payload FIFO
   // ----------------------------------------------------------------------

   localparam int PYLD_DEPTH = 64;
   localparam int PTR_W      = $clog2(PYLD_DEPTH);

   // tuser on the header streams holds the tag in its low bits.
   // The top bit flags a packet that ended inside its header.
   localparam int TUSER_W       = TAG_W + 1;
   localparam int TUSER_NO_PYLD = TAG_W;

   // one payload beat as it sits in the FIFO, 78 bits in all.
   typedef struct packed {
      logic [DATA_W-1:0]     data;
      logic [DATA_BYTES-1:0] keep;
      logic                  last;
      logic                  first;
      logic [TAG_W-1:0]      tag;
   } pyld_entry_t;

endpackage

`default_nettype wire

// ==== src/hdr_splitter.sv ====
/* Divides each input packet into header beats for the header processor and payload
   beats for the payload FIFO; with a zero header length whole packets go out as headers. */

`timescale 1ns/1ns
`default_nettype none

module hdr_splitter
   import hdr_split_join_pkg::*;
(
   input  logic                  clk,
   input  logic                  srst,

   input  logic                  in_valid,
   output logic                  in_ready,
   input  logic [DATA_W-1:0]     in_data,
   input  logic [DATA_BYTES-1:0] in_keep,
   input  logic                  in_last,

   output logic                  hdr_out_valid,
   input  logic                  hdr_out_ready,
   output logic [DATA_W-1:0]     hdr_out_data,
   output logic [DATA_BYTES-1:0] hdr_out_keep,
   output logic                  hdr_out_last,
   output logic [TUSER_W-1:0]    hdr_out_user,

   input  logic [15:0]           hdr_length,
   input  logic                  full,
   output logic                  wr_en,
   output pyld_entry_t           wr_entry,
   output logic                  enable
);

   logic             run;
   logic [15:0]      beat_cnt;
   logic [15:0]      hdr_beats_q;
   logic [15:0]      hdr_beats;
   logic [TAG_W-1:0] tag;
   logic             sop;
   logic             split_on;
   logic             is_hdr;
   logic             hdr_end;
   logic             accept;

   // ----------------------------------------------------------------------
   // beat classification
   // ----------------------------------------------------------------------

   // the header length is taken live on the first beat and held for the rest.
   assign sop       = (beat_cnt == '0);
   assign hdr_beats = sop ? (hdr_length >> $clog2(DATA_BYTES)) : hdr_beats_q;
   assign split_on  = (hdr_beats != '0);
   assign is_hdr    = !split_on || (beat_cnt < hdr_beats);
   assign hdr_end   = split_on && (beat_cnt == hdr_beats - 16'd1);

   // a header beat needs room in the output register, a payload beat in the FIFO.
   assign in_ready = run && (is_hdr ? (!hdr_out_valid || hdr_out_ready) : !full);
   assign accept   = in_valid && in_ready;

   // ----------------------------------------------------------------------
   // packet tracking
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (srst) begin
         run         <= 1'b0;
         beat_cnt    <= '0;
         hdr_beats_q <= '0;
         tag         <= '0;
         enable      <= 1'b0;
      end else begin
         run <= 1'b1;
         if (accept) begin
            if (sop) begin
               hdr_beats_q <= hdr_beats;
               enable      <= split_on;
            end
            // the count stops one past the header so that first is seen once.
            if (in_last) begin
               beat_cnt <= '0;
               tag      <= tag + 1'b1;
            end else if (beat_cnt <= hdr_beats) begin
               beat_cnt <= beat_cnt + 16'd1;
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // header output register
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (srst) begin
         hdr_out_valid <= 1'b0;
      end else if (accept && is_hdr) begin
         hdr_out_valid <= 1'b1;
      end else if (hdr_out_ready) begin
         hdr_out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept && is_hdr) begin
         hdr_out_data <= in_data;
         hdr_out_keep <= in_keep;
         hdr_out_last <= in_last || hdr_end;
         // no payload follows when the packet ends inside its header.
         hdr_out_user <= {split_on && in_last, tag};
      end
   end

   // ----------------------------------------------------------------------
   // payload FIFO write register
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (srst) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= accept && !is_hdr;
      end
   end

   always_ff @(posedge clk) begin
      if (accept && !is_hdr) begin
         wr_entry.data  <= in_data;
         wr_entry.keep  <= in_keep;
         wr_entry.last  <= in_last;
         wr_entry.first <= (beat_cnt == hdr_beats);
         wr_entry.tag   <= tag;
      end
   end

endmodule

`default_nettype wire

// ==== src/pyld_fifo.sv ====
/* Synchronous circular buffer for tagged payload beats, written by the splitter and
   drained by the joiner through a registered read port. */

`timescale 1ns/1ns
`default_nettype none

module pyld_fifo
   import hdr_split_join_pkg::*;
(
   input  logic        clk,
   input  logic        srst,

   input  logic        wr_en,
   input  pyld_entry_t wr_entry,
   output logic        full,

   output logic        rd_valid,
   output pyld_entry_t rd_entry,
   input  logic        rd_en
);

   pyld_entry_t      mem [PYLD_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             mem_rd;

   // one slot stays free for the beat already held in the splitter's write register.
   assign full = (count >= PYLD_DEPTH - 1);

   // refill the read register whenever it is empty or being taken.
   assign mem_rd = (count != '0) && (!rd_valid || rd_en);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_entry;
      end
   end

   always_ff @(posedge clk) begin
      if (mem_rd) begin
         rd_entry <= mem[rd_ptr];
      end
   end

   // ----------------------------------------------------------------------
   // pointers and occupancy
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (srst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         rd_valid <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (mem_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, mem_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (mem_rd) begin
            rd_valid <= 1'b1;
         end else if (rd_en) begin
            rd_valid <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/hdr_joiner.sv ====
/* Rejoins each processed header with its payload from the FIFO, drops payloads whose
   header went missing and keeps a sticky mismatch flag; passes headers through in bypass. */

`timescale 1ns/1ns
`default_nettype none

module hdr_joiner
   import hdr_split_join_pkg::*;
(
   input  logic                  clk,
   input  logic                  srst,
   input  logic                  enable,

   input  logic                  hdr_in_valid,
   output logic                  hdr_in_ready,
   input  logic [DATA_W-1:0]     hdr_in_data,
   input  logic [DATA_BYTES-1:0] hdr_in_keep,
   input  logic                  hdr_in_last,
   input  logic [TUSER_W-1:0]    hdr_in_user,

   input  logic                  rd_valid,
   input  pyld_entry_t           rd_entry,
   output logic                  rd_en,

   output logic                  out_valid,
   input  logic                  out_ready,
   output logic [DATA_W-1:0]     out_data,
   output logic [DATA_BYTES-1:0] out_keep,
   output logic                  out_last,

   input  logic                  sop_mismatch_clr,
   output logic                  sop_mismatch
);

   typedef enum logic [1:0] {
      S_HDR,
      S_PYLD,
      S_DROP
   } state_t;

   state_t           state;
   logic             run;
   logic [TAG_W-1:0] tag_q;
   logic             out_free;
   logic             hdr_no_pyld;
   logic             hdr_take;
   logic             pyld_take;
   logic             mismatch;

   // ----------------------------------------------------------------------
   // handshakes
   // ----------------------------------------------------------------------

   assign out_free    = !out_valid || out_ready;
   assign hdr_no_pyld = hdr_in_user[TUSER_NO_PYLD];

   // in bypass the header stream always flows, otherwise only between payloads.
   assign hdr_in_ready = run && out_free && (!enable || state == S_HDR);
   assign hdr_take     = hdr_in_valid && hdr_in_ready;

   // only the first entry of a payload carries a tag worth checking.
   assign mismatch  = enable && (state == S_PYLD) && rd_valid && rd_entry.first &&
                      (rd_entry.tag != tag_q);
   assign pyld_take = enable && (state == S_PYLD) && rd_valid && !mismatch && out_free;

   // a mismatched or dropped entry is consumed without touching out.
   assign rd_en = pyld_take || mismatch || (enable && (state == S_DROP) && rd_valid);

   // ----------------------------------------------------------------------
   // FSM
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (srst) begin
         run   <= 1'b0;
         state <= S_HDR;
      end else begin
         run <= 1'b1;
         if (!enable) begin
            state <= S_HDR;
         end else begin
            case (state)
               S_HDR: begin
                  if (hdr_take && hdr_in_last && !hdr_no_pyld) begin
                     state <= S_PYLD;
                  end
               end
               S_PYLD: begin
                  if (mismatch && !rd_entry.last) begin
                     state <= S_DROP;
                  end else if (pyld_take && rd_entry.last) begin
                     state <= S_HDR;
                  end
               end
               S_DROP: begin
                  // after the orphan, the next payload belongs to the held header.
                  if (rd_valid && rd_entry.last) begin
                     state <= S_PYLD;
                  end
               end
               default: state <= S_HDR;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_take && hdr_in_last) begin
         tag_q <= hdr_in_user[TAG_W-1:0];
      end
   end

   // ----------------------------------------------------------------------
   // output register
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (srst) begin
         out_valid <= 1'b0;
      end else if (hdr_take || pyld_take) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_take) begin
         out_data <= hdr_in_data;
         out_keep <= hdr_in_keep;
         out_last <= enable ? (hdr_in_last && hdr_no_pyld) : hdr_in_last;
      end else if (pyld_take) begin
         out_data <= rd_entry.data;
         out_keep <= rd_entry.keep;
         out_last <= rd_entry.last;
      end
   end

   // the flag is sticky and a fresh mismatch wins over a clear in the same cycle.
   always_ff @(posedge clk) begin
      if (srst) begin
         sop_mismatch <= 1'b0;
      end else if (mismatch) begin
         sop_mismatch <= 1'b1;
      end else if (sop_mismatch_clr) begin
         sop_mismatch <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== src/hdr_split_join.sv ====
/* Top level of the header split and join subsystem; connects the splitter, the
   payload FIFO and the joiner around an external header processor. */

`timescale 1ns/1ns
`default_nettype none

module hdr_split_join
   import hdr_split_join_pkg::*;
(
   input  logic                  clk,
   input  logic                  srst,

   input  logic                  in_valid,
   output logic                  in_ready,
   input  logic [DATA_W-1:0]     in_data,
   input  logic [DATA_BYTES-1:0] in_keep,
   input  logic                  in_last,

   output logic                  hdr_out_valid,
   input  logic                  hdr_out_ready,
   output logic [DATA_W-1:0]     hdr_out_data,
   output logic [DATA_BYTES-1:0] hdr_out_keep,
   output logic                  hdr_out_last,
   output logic [TUSER_W-1:0]    hdr_out_user,

   input  logic                  hdr_in_valid,
   output logic                  hdr_in_ready,
   input  logic [DATA_W-1:0]     hdr_in_data,
   input  logic [DATA_BYTES-1:0] hdr_in_keep,
   input  logic                  hdr_in_last,
   input  logic [TUSER_W-1:0]    hdr_in_user,

   output logic                  out_valid,
   input  logic                  out_ready,
   output logic [DATA_W-1:0]     out_data,
   output logic [DATA_BYTES-1:0] out_keep,
   output logic                  out_last,

   input  logic [15:0]           hdr_length,
   output logic                  sop_mismatch,
   input  logic                  sop_mismatch_clr
);

   logic        enable;
   logic        full;
   logic        wr_en;
   pyld_entry_t wr_entry;
   logic        rd_valid;
   pyld_entry_t rd_entry;
   logic        rd_en;
   logic        fifo_srst;

   // the payload FIFO is held empty whenever the split is off.
   assign fifo_srst = srst || !enable;

   hdr_splitter hdr_splitter_inst (
      .clk           (clk),
      .srst          (srst),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .in_data       (in_data),
      .in_keep       (in_keep),
      .in_last       (in_last),
      .hdr_out_valid (hdr_out_valid),
      .hdr_out_ready (hdr_out_ready),
      .hdr_out_data  (hdr_out_data),
      .hdr_out_keep  (hdr_out_keep),
      .hdr_out_last  (hdr_out_last),
      .hdr_out_user  (hdr_out_user),
      .hdr_length    (hdr_length),
      .full          (full),
      .wr_en         (wr_en),
      .wr_entry      (wr_entry),
      .enable        (enable)
   );

   pyld_fifo pyld_fifo_inst (
      .clk      (clk),
      .srst     (fifo_srst),
      .wr_en    (wr_en),
      .wr_entry (wr_entry),
      .full     (full),
      .rd_valid (rd_valid),
      .rd_entry (rd_entry),
      .rd_en    (rd_en)
   );

   hdr_joiner hdr_joiner_inst (
      .clk              (clk),
      .srst             (srst),
      .enable           (enable),
      .hdr_in_valid     (hdr_in_valid),
      .hdr_in_ready     (hdr_in_ready),
      .hdr_in_data      (hdr_in_data),
      .hdr_in_keep      (hdr_in_keep),
      .hdr_in_last      (hdr_in_last),
      .hdr_in_user      (hdr_in_user),
      .rd_valid         (rd_valid),
      .rd_entry         (rd_entry),
      .rd_en            (rd_en),
      .out_valid        (out_valid),
      .out_ready        (out_ready),
      .out_data         (out_data),
      .out_keep         (out_keep),
      .out_last         (out_last),
      .sop_mismatch_clr (sop_mismatch_clr),
      .sop_mismatch     (sop_mismatch)
   );

endmodule

`default_nettype wire

// ==== dv/hdr_split_join_assertions.sv ====
/* Stream protocol and mismatch flag checks for the header split and join top level,
   attached to every instance of it with bind. */

`timescale 1ns/1ns
`default_nettype none

module hdr_split_join_assertions
   import hdr_split_join_pkg::*;
(
   input logic                  clk,
   input logic                  srst,
   input logic                  in_valid,
   input logic                  in_ready,
   input logic [DATA_W-1:0]     in_data,
   input logic [DATA_BYTES-1:0] in_keep,
   input logic                  in_last,
   input logic                  hdr_out_valid,
   input logic                  hdr_out_ready,
   input logic [DATA_W-1:0]     hdr_out_data,
   input logic [DATA_BYTES-1:0] hdr_out_keep,
   input logic                  hdr_out_last,
   input logic [TUSER_W-1:0]    hdr_out_user,
   input logic                  hdr_in_valid,
   input logic                  hdr_in_ready,
   input logic [DATA_W-1:0]     hdr_in_data,
   input logic [DATA_BYTES-1:0] hdr_in_keep,
   input logic                  hdr_in_last,
   input logic [TUSER_W-1:0]    hdr_in_user,
   input logic                  out_valid,
   input logic                  out_ready,
   input logic [DATA_W-1:0]     out_data,
   input logic [DATA_BYTES-1:0] out_keep,
   input logic                  out_last,
   input logic [15:0]           hdr_length,
   input logic                  sop_mismatch
);

   int fail_cnt = 0;

   // ----------------------------------------------------------------------
   // a stalled beat keeps valid high and its contents unchanged.
   // ----------------------------------------------------------------------

   in_hold: assert property (@(posedge clk) disable iff (srst)
      in_valid && !in_ready |=> in_valid && $stable({in_data, in_keep, in_last}))
      else begin
         $error("in beat changed while stalled");
         fail_cnt++;
      end

   hdr_out_hold: assert property (@(posedge clk) disable iff (srst)
      hdr_out_valid && !hdr_out_ready |=> hdr_out_valid &&
         $stable({hdr_out_data, hdr_out_keep, hdr_out_last, hdr_out_user}))
      else begin
         $error("hdr_out beat changed while stalled");
         fail_cnt++;
      end

   hdr_in_hold: assert property (@(posedge clk) disable iff (srst)
      hdr_in_valid && !hdr_in_ready |=> hdr_in_valid &&
         $stable({hdr_in_data, hdr_in_keep, hdr_in_last, hdr_in_user}))
      else begin
         $error("hdr_in beat changed while stalled");
         fail_cnt++;
      end

   out_hold: assert property (@(posedge clk) disable iff (srst)
      out_valid && !out_ready |=> out_valid && $stable({out_data, out_keep, out_last}))
      else begin
         $error("out beat changed while stalled");
         fail_cnt++;
      end

   // the flag and both output valids come out of reset low.
   reset_state: assert property (@(posedge clk)
      srst |=> !sop_mismatch && !out_valid && !hdr_out_valid)
      else begin
         $error("flag or valid high after reset");
         fail_cnt++;
      end

   // headers are whole beats.
   hdr_len_whole: assert property (@(posedge clk) disable iff (srst)
      hdr_length[2:0] == 3'b000)
      else begin
         $error("hdr_length is not a multiple of 8");
         fail_cnt++;
      end

endmodule

bind hdr_split_join hdr_split_join_assertions hdr_split_join_assertions_inst (.*);

`default_nettype wire

// ==== dv/hdr_split_join_tb.sv ====
/* Testbench for the header split and join subsystem. Sends random packets through
   split, short, bypass, back-pressure and lost-header runs and scores the out stream. */

`timescale 1ns/1ns
`default_nettype none

module hdr_split_join_tb
   import hdr_split_join_pkg::*;
;

   localparam logic [31:0]       SEED     = 32'hf005_002f;
   localparam logic [DATA_W-1:0] PROC_XOR = 64'ha5a5_0ff0_5a5a_f00f;
   localparam int NUM_PKT = 60;
   localparam int MAX_LEN = 12;
   // 60 packets of up to 12 beats take a few cycles per beat under random ready on both sides.
   localparam int TIMEOUT_CYCLES = 6000;

   logic clk, srst;
   logic in_valid, in_ready, in_last;
   logic [DATA_W-1:0] in_data, hdr_out_data, hdr_in_data, out_data;
   logic [DATA_BYTES-1:0] in_keep, hdr_out_keep, hdr_in_keep, out_keep;
   logic hdr_out_valid, hdr_out_ready, hdr_out_last;
   logic hdr_in_valid, hdr_in_ready, hdr_in_last;
   logic [TUSER_W-1:0] hdr_out_user, hdr_in_user;
   logic out_valid, out_ready, out_last;
   logic [15:0] hdr_length;
   logic sop_mismatch, sop_mismatch_clr;

   integer seed;
   logic [31:0] rnd;
   logic bp_mode;
   int cycle_cnt, pkt_idx, hdr_grp, drop_grp;
   string cur_test;
   int pkt_len [NUM_PKT];
   logic [DATA_W-1:0] pkt_salt [NUM_PKT];
   logic [DATA_BYTES-1:0] pkt_keep [NUM_PKT];
   // expected out beats are {last, keep, data} and processed headers are {user, last, keep, data}.
   logic [DATA_W+DATA_BYTES:0] exp_q [$];
   logic [DATA_W+DATA_BYTES+TUSER_W:0] proc_q [$];

   hdr_split_join hdr_split_join_inst (.*);

   always #5 clk = ~clk;

   task automatic fail_now();
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_value(input string what, input logic [DATA_W+DATA_BYTES:0] exp,
                              input logic [DATA_W+DATA_BYTES:0] act);
      if (exp !== act) begin
         $display("[FAIL] %s %s expected %0h actual %0h", cur_test, what, exp, act);
         fail_now();
      end
   endtask

   function automatic logic [DATA_W-1:0] beat_data(input int p, input int b);
      return pkt_salt[p] + 64'(b) * 64'h0101_0101_0101_0101;
   endfunction

   task automatic send_beat(input logic [DATA_W-1:0] d, input logic [DATA_BYTES-1:0] k,
                            input logic l);
      in_valid = 1'b1;
      in_data  = d;
      in_keep  = k;
      in_last  = l;
      @(negedge clk);
      while (!in_ready) @(negedge clk);
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      do begin
         @(posedge clk);
      end while (exp_q.size() != 0);
      repeat (2) @(posedge clk);
      #1;
   endtask

   // ----------------------------------------------------------------------
   // each test run derives its expected beats from the header length and the XOR.
   // ----------------------------------------------------------------------

   task automatic run_test(input string name, input int n_pkt, input int hlen, input bit bp,
                           input bit short_pkts, input int drop_at);
      int len;
      int hdr_beats;
      int p;
      logic [DATA_BYTES-1:0] k;
      cur_test   = name;
      hdr_length = 16'(hlen);
      bp_mode    = bp;
      hdr_beats  = (hlen == 0) ? MAX_LEN : hlen / DATA_BYTES;
      for (int i = 0; i < n_pkt; i++) begin
         p   = pkt_idx;
         len = short_pkts ? (pkt_len[p] % 2) + 1 : pkt_len[p];
         // the lost-header run needs payloads so that the orphan is seen.
         if (drop_at >= 0 && len < 3)
            len = 3;
         if (i == drop_at)
            drop_grp = p;
         for (int b = 0; b < len; b++) begin
            k = (b == len - 1) ? pkt_keep[p] : '1;
            if (i != drop_at)
               exp_q.push_back({b == len - 1, k,
                                (b < hdr_beats) ? beat_data(p, b) ^ PROC_XOR : beat_data(p, b)});
         end
         for (int b = 0; b < len; b++)
            send_beat(beat_data(p, b), (b == len - 1) ? pkt_keep[p] : '1, b == len - 1);
         pkt_idx++;
      end
      wait_drain();
   endtask

   // ----------------------------------------------------------------------
   // header processor model, ready patterns, scoreboard and watchdogs
   // ----------------------------------------------------------------------

   always begin
      @(posedge clk);
      #1;
      hdr_in_valid = (proc_q.size() != 0);
      if (proc_q.size() != 0)
         {hdr_in_user, hdr_in_last, hdr_in_keep, hdr_in_data} = proc_q[0];
      @(negedge clk);
      if (hdr_in_valid && hdr_in_ready)
         void'(proc_q.pop_front());
      if (hdr_out_valid && hdr_out_ready) begin
         if (hdr_grp != drop_grp)
            proc_q.push_back({hdr_out_user, hdr_out_last, hdr_out_keep,
                              hdr_out_data ^ PROC_XOR});
         if (hdr_out_last)
            hdr_grp++;
      end
   end

   always begin
      @(posedge clk);
      #1;
      rnd           = $random(seed);
      hdr_out_ready = bp_mode ? rnd[0] : 1'b1;
      out_ready     = bp_mode ? rnd[1] : 1'b1;
   end

   always begin
      @(negedge clk);
      if (out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("out delivered a beat that no packet accounts for during %s", cur_test);
            fail_now();
         end else begin
            check_value("out beat", exp_q[0], {out_last, out_keep, out_data});
            void'(exp_q.pop_front());
         end
      end
      if (hdr_split_join_inst.hdr_split_join_assertions_inst.fail_cnt != 0) begin
         $display("a protocol assertion failed during %s", cur_test);
         fail_now();
      end
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         fail_now();
      end
   end

   initial begin
      clk              = 0;
      srst             = 1;
      seed             = SEED;
      bp_mode          = 0;
      in_valid         = 0;
      in_data          = '0;
      in_keep          = '0;
      in_last          = 0;
      hdr_in_valid     = 0;
      hdr_in_data      = '0;
      hdr_in_keep      = '0;
      hdr_in_last      = 0;
      hdr_in_user      = '0;
      hdr_out_ready    = 0;
      out_ready        = 0;
      hdr_length       = 16'd16;
      sop_mismatch_clr = 0;
      cycle_cnt        = 0;
      pkt_idx          = 0;
      hdr_grp          = 0;
      drop_grp         = -1;
      cur_test         = "reset";
      for (int p = 0; p < NUM_PKT; p++) begin
         pkt_len[p]         = 1 + ($unsigned($random(seed)) % MAX_LEN);
         pkt_salt[p][63:32] = $random(seed);
         pkt_salt[p][31:0]  = $random(seed);
         pkt_keep[p]        = 8'hff >> ($unsigned($random(seed)) % DATA_BYTES);
      end
      repeat (2) @(posedge clk);
      #1;
      srst = 0;
      run_test("split_rejoin", 12, 16, 0, 0, -1);
      run_test("short_packets", 8, 16, 0, 1, -1);
      run_test("bypass", 12, 0, 0, 0, -1);
      run_test("back_pressure_split", 12, 16, 1, 0, -1);
      run_test("back_pressure_bypass", 8, 0, 1, 0, -1);
      check_value("sop_mismatch", 0, sop_mismatch);
      run_test("lost_header", 8, 16, 0, 0, 3);
      check_value("sop_mismatch", 1, sop_mismatch);
      sop_mismatch_clr = 1;
      @(posedge clk);
      #1;
      sop_mismatch_clr = 0;
      check_value("sop_mismatch after clear", 0, sop_mismatch);
      if (hdr_split_join_inst.hdr_split_join_assertions_inst.fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         $display("a protocol assertion failed before the end of the run");
         fail_now();
      end
   end

endmodule

`default_nettype wire

// ==== project.f ====
src/hdr_split_join_pkg.sv
src/hdr_splitter.sv
src/pyld_fifo.sv
src/hdr_joiner.sv
src/hdr_split_join.sv
dv/hdr_split_join_assertions.sv
dv/hdr_split_join_tb.sv
